// File: Makefile
# Verilator build and run for the pointer allocator testbench

VERILATOR ?= verilator
TOP       ?= tb_ptr_alloc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: alloc_bv_core.sv
// Allocator core: scan FSM, read-modify-write FSM, read-tag delay line, alloc and dealloc queues
`timescale 1ns/1ps

module alloc_bv_core #(
    parameter int ALLOC_Q_DEPTH   = 8,
    parameter int DEALLOC_Q_DEPTH = 8,
    parameter int MEM_RD_LATENCY  = 2
) (
    input  logic              clk,
    input  logic              srst,
    input  logic              en,
    input  logic              scan_en,
    input  alloc_pkg::count_t ptr_limit,
    input  logic              alloc_req,
    output logic              alloc_rdy,
    output alloc_pkg::ptr_t   alloc_ptr,
    input  logic              dealloc_req,
    output logic              dealloc_rdy,
    input  alloc_pkg::ptr_t   dealloc_ptr,
    output logic              mem_rd,
    output alloc_pkg::row_t   mem_rd_row,
    input  alloc_pkg::vec_t   mem_rd_data,
    output logic              mem_wr,
    output alloc_pkg::row_t   mem_wr_row,
    output alloc_pkg::vec_t   mem_wr_data,
    input  logic              mem_init_done,
    output logic              mon_alloc,
    output logic              mon_dealloc,
    output logic              mon_alloc_err,
    output logic              mon_dealloc_err
);
    import alloc_pkg::*;

    typedef enum logic [3:0] {
        ENG_RESET, ENG_IDLE, ENG_DEALLOC, ENG_ALLOC, ENG_RD_REQ,
        ENG_RD_WAIT, ENG_MODIFY, ENG_WR, ENG_DONE, ENG_ERROR
    } eng_state_t;

    typedef enum logic [2:0] {
        SCAN_RESET, SCAN_IDLE, SCAN_RD_REQ, SCAN_RD_WAIT,
        SCAN_CHECK, SCAN_NEXT, SCAN_HOLD
    } scan_state_t;

    eng_state_t  eng_state;
    eng_state_t  eng_nxt;
    scan_state_t scan_state;
    scan_state_t scan_nxt;

    // Queue handshakes
    logic alloc_q_wr;
    logic alloc_q_wr_rdy;
    logic dealloc_q_rd;
    logic dealloc_q_vld;
    ptr_t dealloc_q_data;

    // Engine datapath
    logic eng_rd;
    logic eng_modify;
    logic eng_wr;
    logic eng_done;
    logic eng_err;
    logic op_alloc;
    ptr_t eng_ptr;
    vec_t eng_vec;
    vec_t eng_wr_vec;
    vec_t col_mask;
    logic bit_is_target;

    // Scanner datapath
    logic scan_rd;
    logic scan_check;
    logic scan_next;
    logic scan_claim;
    logic scan_hit;
    row_t scan_row;
    col_t scan_col;
    col_t hit_col;
    vec_t scan_vec;

    // Limit boundary
    ptr_t last_ptr;
    row_t last_row;
    col_t last_col;

    // Read tags, scan bit set for scanner reads
    logic [MEM_RD_LATENCY-1:0] tag_vld;
    logic [MEM_RD_LATENCY-1:0] tag_scan;
    logic                      eng_rd_ack;
    logic                      scan_rd_ack;

    // ----------------------------------------------------------
    // Queues
    // ----------------------------------------------------------

    // Claimed pointer pushed in the claim cycle
    fifo_sync #(
        .DATA_WID ( PTR_WID ),
        .DEPTH    ( ALLOC_Q_DEPTH )
    ) u_alloc_q (
        .clk,
        .srst,
        .wr      ( alloc_q_wr ),
        .wr_data ( {scan_row, scan_col} ),
        .wr_rdy  ( alloc_q_wr_rdy ),
        .rd      ( alloc_req ),
        .rd_vld  ( alloc_rdy ),
        .rd_data ( alloc_ptr )
    );

    fifo_sync #(
        .DATA_WID ( PTR_WID ),
        .DEPTH    ( DEALLOC_Q_DEPTH )
    ) u_dealloc_q (
        .clk,
        .srst,
        .wr      ( dealloc_req ),
        .wr_data ( dealloc_ptr ),
        .wr_rdy  ( dealloc_rdy ),
        .rd      ( dealloc_q_rd ),
        .rd_vld  ( dealloc_q_vld ),
        .rd_data ( dealloc_q_data )
    );

    // ----------------------------------------------------------
    // Memory access and read tags
    // ----------------------------------------------------------

    assign mem_rd      = eng_rd || scan_rd;
    // Engine owns the read port when it reads
    assign mem_rd_row  = eng_rd ? eng_ptr[COL_WID +: ROW_WID] : scan_row;
    assign mem_wr      = eng_wr;
    assign mem_wr_row  = eng_ptr[COL_WID +: ROW_WID];
    assign mem_wr_data = eng_wr_vec;

    always_ff @(posedge clk) begin
        if (srst) begin
            tag_vld <= '0;
        end else begin
            tag_vld[0] <= mem_rd;
            for (int i = 1; i < MEM_RD_LATENCY; i++) begin
                tag_vld[i] <= tag_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_scan[0] <= !eng_rd;
        for (int i = 1; i < MEM_RD_LATENCY; i++) begin
            tag_scan[i] <= tag_scan[i-1];
        end
    end

    // Steer the return to its owner
    assign eng_rd_ack  = tag_vld[MEM_RD_LATENCY-1] && !tag_scan[MEM_RD_LATENCY-1];
    assign scan_rd_ack = tag_vld[MEM_RD_LATENCY-1] &&  tag_scan[MEM_RD_LATENCY-1];

    // ----------------------------------------------------------
    // Read-modify-write engine
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            eng_state <= ENG_RESET;
        end else begin
            eng_state <= eng_nxt;
        end
    end

    always_comb begin
        eng_nxt      = eng_state;
        dealloc_q_rd = 1'b0;
        alloc_q_wr   = 1'b0;
        eng_rd       = 1'b0;
        eng_modify   = 1'b0;
        eng_wr       = 1'b0;
        eng_done     = 1'b0;
        eng_err      = 1'b0;
        case (eng_state)
            ENG_RESET: begin
                if (mem_init_done) eng_nxt = ENG_IDLE;
            end
            ENG_IDLE: begin
                // Deallocation first
                if (dealloc_q_vld) begin
                    eng_nxt = ENG_DEALLOC;
                end else if (en && alloc_q_wr_rdy && scan_state == SCAN_HOLD) begin
                    eng_nxt = ENG_ALLOC;
                end
            end
            ENG_DEALLOC: begin
                dealloc_q_rd = 1'b1;
                eng_nxt      = ENG_RD_REQ;
            end
            ENG_ALLOC: begin
                // Claim: pointer goes to the queue now
                alloc_q_wr = 1'b1;
                eng_nxt    = ENG_RD_REQ;
            end
            ENG_RD_REQ: begin
                eng_rd  = 1'b1;
                eng_nxt = ENG_RD_WAIT;
            end
            ENG_RD_WAIT: begin
                if (eng_rd_ack) eng_nxt = ENG_MODIFY;
            end
            ENG_MODIFY: begin
                eng_modify = 1'b1;
                eng_nxt    = bit_is_target ? ENG_ERROR : ENG_WR;
            end
            ENG_WR: begin
                eng_wr  = 1'b1;
                eng_nxt = ENG_DONE;
            end
            ENG_DONE: begin
                eng_done = 1'b1;
                eng_nxt  = ENG_IDLE;
            end
            ENG_ERROR: begin
                // Write skipped, bit left as found
                eng_err = 1'b1;
                eng_nxt = ENG_IDLE;
            end
            default: eng_nxt = ENG_RESET;
        endcase
    end

    // Latch operation and pointer
    always_ff @(posedge clk) begin
        if (eng_state == ENG_DEALLOC) begin
            op_alloc <= 1'b0;
            eng_ptr  <= dealloc_q_data;
        end else if (eng_state == ENG_ALLOC) begin
            op_alloc <= 1'b1;
            eng_ptr  <= {scan_row, scan_col};
        end
    end

    always_ff @(posedge clk) begin
        if (eng_rd) col_mask <= vec_t'(1) << eng_ptr[0 +: COL_WID];
        if (eng_rd_ack) eng_vec <= mem_rd_data;
        // Allocate clears the bit, deallocate sets it
        if (eng_modify) eng_wr_vec <= op_alloc ? (eng_vec & ~col_mask) : (eng_vec | col_mask);
    end

    // Target is 0 for allocate, 1 for deallocate
    assign bit_is_target = ((eng_vec & col_mask) != '0) == !op_alloc;

    // ----------------------------------------------------------
    // Scanner
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            scan_state <= SCAN_RESET;
        end else begin
            scan_state <= scan_nxt;
        end
    end

    always_comb begin
        scan_nxt   = scan_state;
        scan_rd    = 1'b0;
        scan_check = 1'b0;
        scan_next  = 1'b0;
        scan_claim = 1'b0;
        case (scan_state)
            SCAN_RESET: begin
                if (mem_init_done) scan_nxt = SCAN_IDLE;
            end
            SCAN_IDLE: begin
                if (scan_en) scan_nxt = SCAN_RD_REQ;
            end
            SCAN_RD_REQ: begin
                // Only while the engine is idle, so no claimed write is still pending
                if (eng_state == ENG_IDLE) begin
                    scan_rd  = 1'b1;
                    scan_nxt = SCAN_RD_WAIT;
                end
            end
            SCAN_RD_WAIT: begin
                if (scan_rd_ack) scan_nxt = SCAN_CHECK;
            end
            SCAN_CHECK: begin
                scan_check = 1'b1;
                scan_nxt   = scan_hit ? SCAN_HOLD : SCAN_NEXT;
            end
            SCAN_NEXT: begin
                scan_next = 1'b1;
                scan_nxt  = SCAN_IDLE;
            end
            SCAN_HOLD: begin
                // Wait for the engine to claim, then look again
                if (eng_state == ENG_ALLOC) begin
                    scan_claim = 1'b1;
                    scan_nxt   = SCAN_CHECK;
                end
            end
            default: scan_nxt = SCAN_RESET;
        endcase
    end

    // Last pointer within the limit, zero or oversize means the whole pool
    assign last_ptr = (ptr_limit == '0 || ptr_limit > count_t'(NUM_ROWS * NUM_COLS)) ?
                      '1 : ptr_t'(ptr_limit - 1'b1);
    assign last_row = last_ptr[COL_WID +: ROW_WID];
    assign last_col = last_ptr[0 +: COL_WID];

    // Row walk wraps after the last row in use
    always_ff @(posedge clk) begin
        if (srst) begin
            scan_row <= '0;
        end else if (scan_next) begin
            scan_row <= (scan_row >= last_row) ? '0 : scan_row + 1'b1;
        end
    end

    // Local row copy; claimed bit marked used
    always_ff @(posedge clk) begin
        if (scan_rd_ack) begin
            scan_vec <= mem_rd_data;
        end else if (scan_claim) begin
            scan_vec[scan_col] <= 1'b0;
        end
    end

    // Lowest free column within the limit
    always_comb begin
        scan_hit = 1'b0;
        hit_col  = '0;
        for (int i = NUM_COLS - 1; i >= 0; i--) begin
            if (scan_vec[i] && (scan_row < last_row ||
                                (scan_row == last_row && col_t'(i) <= last_col))) begin
                scan_hit = 1'b1;
                hit_col  = col_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_check) scan_col <= hit_col;
    end

    // ----------------------------------------------------------
    // Monitor strobes
    // ----------------------------------------------------------

    assign mon_alloc       = alloc_req && alloc_rdy;
    assign mon_dealloc     = eng_done && !op_alloc;
    assign mon_alloc_err   = eng_err && op_alloc;
    assign mon_dealloc_err = eng_err && !op_alloc;

endmodule

// File: alloc_mon.sv
// Allocator event counters and in-use pointer count
`timescale 1ns/1ps

module alloc_mon (
    input  logic              clk,
    input  logic              srst,
    input  logic              mon_alloc,
    input  logic              mon_dealloc,
    input  logic              mon_alloc_err,
    input  logic              mon_dealloc_err,
    output alloc_pkg::stat_t  alloc_count,
    output alloc_pkg::stat_t  dealloc_count,
    output alloc_pkg::stat_t  err_count,
    output alloc_pkg::count_t in_use
);
    // Event counters saturate at all-ones
    always_ff @(posedge clk) begin
        if (srst) begin
            alloc_count   <= '0;
            dealloc_count <= '0;
            err_count     <= '0;
        end else begin
            if (mon_alloc && alloc_count != '1) begin
                alloc_count <= alloc_count + 1'b1;
            end
            if (mon_dealloc && dealloc_count != '1) begin
                dealloc_count <= dealloc_count + 1'b1;
            end
            // Errors of both kinds share one counter
            if ((mon_alloc_err || mon_dealloc_err) && err_count != '1) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // Pointers handed out and not yet returned
    always_ff @(posedge clk) begin
        if (srst) begin
            in_use <= '0;
        end else begin
            case ({mon_alloc, mon_dealloc})
                2'b10: in_use <= in_use + 1'b1;
                // Queued pointers may come back without a handout, so no wrap below zero
                2'b01: in_use <= (in_use != '0) ? in_use - 1'b1 : in_use;
                default: in_use <= in_use;
            endcase
        end
    end

endmodule

// File: alloc_pkg.sv
// Pool geometry constants and vector typedefs for the pointer allocator
package alloc_pkg;

    // ----------------------------------------------------------
    // Pool geometry
    // ----------------------------------------------------------

    // Pointer is {row, col}, row in the high bits
    localparam int PTR_WID  = 8;

    // State memory shape, one bit per pointer
    localparam int NUM_COLS = 16;
    localparam int NUM_ROWS = 16;

    // Index widths derived from the shape
    localparam int COL_WID  = $clog2(NUM_COLS);
    localparam int ROW_WID  = $clog2(NUM_ROWS);

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------

    // One buffer pointer
    typedef logic [PTR_WID-1:0]  ptr_t;

    // State memory row address
    typedef logic [ROW_WID-1:0]  row_t;

    // Bit position within a row
    typedef logic [COL_WID-1:0]  col_t;

    // One row of free flags, 1 = free
    typedef logic [NUM_COLS-1:0] vec_t;

    // Pointer count or limit, one bit wider so it holds the full pool
    typedef logic [PTR_WID:0]    count_t;

    // Monitor event counter
    typedef logic [15:0]         stat_t;

endpackage

// File: bv_mem.sv
// Bit-vector state RAM with reset-time initializer and fixed-latency read pipeline
`timescale 1ns/1ps

module bv_mem #(
    parameter int MEM_RD_LATENCY = 2
) (
    input  logic            clk,
    input  logic            srst,
    input  logic            mem_rd,
    input  alloc_pkg::row_t mem_rd_row,
    output alloc_pkg::vec_t mem_rd_data,
    input  logic            mem_wr,
    input  alloc_pkg::row_t mem_wr_row,
    input  alloc_pkg::vec_t mem_wr_data,
    output logic            mem_init_done
);
    import alloc_pkg::*;

    vec_t mem     [NUM_ROWS];
    vec_t rd_pipe [MEM_RD_LATENCY];
    row_t init_row;

    // ----------------------------------------------------------
    // Initializer
    // ----------------------------------------------------------

    // One row per cycle after reset, then done
    always_ff @(posedge clk) begin
        if (srst) begin
            init_row      <= '0;
            mem_init_done <= 1'b0;
        end else if (!mem_init_done) begin
            init_row <= init_row + 1'b1;
            if (init_row == row_t'(NUM_ROWS - 1)) begin
                mem_init_done <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    // Init sweep marks every pointer free; core writes only after that
    always_ff @(posedge clk) begin
        if (!mem_init_done) begin
            mem[init_row] <= '1;
        end else if (mem_wr) begin
            mem[mem_wr_row] <= mem_wr_data;
        end
    end

    // ----------------------------------------------------------
    // Read pipeline
    // ----------------------------------------------------------

    // Row sampled at request, then shifted through the remaining stages
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            rd_pipe[0] <= mem[mem_rd_row];
        end
        for (int i = 1; i < MEM_RD_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // Valid exactly MEM_RD_LATENCY cycles after mem_rd
    assign mem_rd_data = rd_pipe[MEM_RD_LATENCY-1];

endmodule

// File: fifo_sync.sv
// Synchronous first-word-fall-through FIFO
`timescale 1ns/1ps

module fifo_sync #(
    parameter int DATA_WID = 8,
    parameter int DEPTH    = 8
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data
);
    // Pointer width, at least one bit even for a single entry
    localparam int ADDR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID  = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [ADDR_WID-1:0] wr_ptr;
    logic [ADDR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0]  count;
    logic                wr_en;
    logic                rd_en;

    // Status from occupancy
    assign wr_rdy = (count != CNT_WID'(DEPTH));
    assign rd_vld = (count != '0);

    // Writes while full and reads while empty are dropped
    assign wr_en = wr && wr_rdy;
    assign rd_en = rd && rd_vld;

    // Head word always visible
    assign rd_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Circular wrap at DEPTH, not necessarily a power of two
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ADDR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ADDR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: ptr_alloc_top.sv
// Pointer allocator top level: core, state memory and monitor
`timescale 1ns/1ps

module ptr_alloc_top #(
    parameter int ALLOC_Q_DEPTH   = 8,
    parameter int DEALLOC_Q_DEPTH = 8,
    parameter int MEM_RD_LATENCY  = 2
) (
    input  logic              clk,
    input  logic              srst,
    input  logic              en,
    input  logic              scan_en,
    input  alloc_pkg::count_t ptr_limit,
    input  logic              alloc_req,
    output logic              alloc_rdy,
    output alloc_pkg::ptr_t   alloc_ptr,
    input  logic              dealloc_req,
    output logic              dealloc_rdy,
    input  alloc_pkg::ptr_t   dealloc_ptr,
    output logic              ready,
    output alloc_pkg::stat_t  alloc_count,
    output alloc_pkg::stat_t  dealloc_count,
    output alloc_pkg::stat_t  err_count,
    output alloc_pkg::count_t in_use
);
    import alloc_pkg::*;

    // Core to memory
    logic mem_rd;
    row_t mem_rd_row;
    vec_t mem_rd_data;
    logic mem_wr;
    row_t mem_wr_row;
    vec_t mem_wr_data;
    logic mem_init_done;

    // Core to monitor
    logic mon_alloc;
    logic mon_dealloc;
    logic mon_alloc_err;
    logic mon_dealloc_err;

    // Ready once every pointer is marked free
    assign ready = mem_init_done;

    alloc_bv_core #(
        .ALLOC_Q_DEPTH   ( ALLOC_Q_DEPTH ),
        .DEALLOC_Q_DEPTH ( DEALLOC_Q_DEPTH ),
        .MEM_RD_LATENCY  ( MEM_RD_LATENCY )
    ) u_core (
        .clk, .srst, .en, .scan_en, .ptr_limit,
        .alloc_req, .alloc_rdy, .alloc_ptr,
        .dealloc_req, .dealloc_rdy, .dealloc_ptr,
        .mem_rd, .mem_rd_row, .mem_rd_data,
        .mem_wr, .mem_wr_row, .mem_wr_data, .mem_init_done,
        .mon_alloc, .mon_dealloc, .mon_alloc_err, .mon_dealloc_err
    );

    bv_mem #(
        .MEM_RD_LATENCY ( MEM_RD_LATENCY )
    ) u_mem (
        .clk, .srst,
        .mem_rd, .mem_rd_row, .mem_rd_data,
        .mem_wr, .mem_wr_row, .mem_wr_data, .mem_init_done
    );

    alloc_mon u_mon (
        .clk, .srst,
        .mon_alloc, .mon_dealloc, .mon_alloc_err, .mon_dealloc_err,
        .alloc_count, .dealloc_count, .err_count, .in_use
    );

endmodule

// File: tb_ptr_alloc.sv
// Directed testbench for the pointer allocator: clock, reset, shadow free list, tests, timeout
`timescale 1ns/1ps

module tb_ptr_alloc;
    import alloc_pkg::*;

    localparam int CYCLE_LIMIT = 200000;
    localparam int IDLE_LIMIT  = 500;
    localparam int POOL_SIZE   = NUM_ROWS * NUM_COLS;

    logic   clk;
    logic   srst;
    logic   en;
    logic   scan_en;
    count_t ptr_limit;
    logic   alloc_req;
    logic   alloc_rdy;
    ptr_t   alloc_ptr;
    logic   dealloc_req;
    logic   dealloc_rdy;
    ptr_t   dealloc_ptr;
    logic   ready;
    stat_t  alloc_count;
    stat_t  dealloc_count;
    stat_t  err_count;
    count_t in_use;

    // Shadow free list, 1 = free
    logic [POOL_SIZE-1:0] shadow_free;
    // Limit as the model sees it, 0 = whole pool
    int                   cur_limit;
    logic [31:0]          rng_state;
    int                   value_errs;
    int                   other_errs;
    int                   cycle_cnt = 0;

    ptr_alloc_top #(
        .ALLOC_Q_DEPTH   ( 8 ),
        .DEALLOC_Q_DEPTH ( 8 ),
        .MEM_RD_LATENCY  ( 2 )
    ) dut (
        .clk, .srst, .en, .scan_en, .ptr_limit,
        .alloc_req, .alloc_rdy, .alloc_ptr,
        .dealloc_req, .dealloc_rdy, .dealloc_ptr,
        .ready, .alloc_count, .dealloc_count, .err_count, .in_use
    );

    // ----------------------------------------------------------
    // Clock and run limit
    // ----------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Reporting and model helpers
    // ----------------------------------------------------------

    task automatic value_err(input string what, input int got, input int exp);
        value_errs++;
        $display("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    endtask

    task automatic other_err(input string msg);
        other_errs++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lowest free pointer below the limit, -1 when none
    function automatic int lowest_free();
        int top;
        top = (cur_limit == 0) ? POOL_SIZE : cur_limit;
        for (int i = 0; i < top; i++) begin
            if (shadow_free[ptr_t'(i)]) return i;
        end
        return -1;
    endfunction

    // Every handout must be the lowest free pointer in the model
    task automatic check_alloc(input ptr_t p);
        int exp_ptr;
        exp_ptr = lowest_free();
        if (exp_ptr < 0) begin
            other_err($sformatf("pointer %0d handed out while none should be free", p));
        end else if (int'(p) != exp_ptr) begin
            value_err("allocated pointer", int'(p), exp_ptr);
        end
        if (!shadow_free[p]) begin
            other_err($sformatf("pointer %0d handed out twice", p));
        end
        shadow_free[p] = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Drivers
    // ----------------------------------------------------------

    task automatic reset_dut(input int lim, input logic en_val, input logic scan_val);
        int wait_cnt;
        @(negedge clk);
        srst        = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        en          = en_val;
        scan_en     = scan_val;
        cur_limit   = lim;
        ptr_limit   = count_t'(lim);
        repeat (2) @(negedge clk);
        srst        = 1'b0;
        shadow_free = '1;
        @(negedge clk);
        // Idle state right after reset
        if (alloc_rdy !== 1'b0) value_err("alloc_rdy after reset", int'(alloc_rdy), 0);
        if (dealloc_rdy !== 1'b1) value_err("dealloc_rdy after reset", int'(dealloc_rdy), 1);
        if (ready !== 1'b0) value_err("ready after reset", int'(ready), 0);
        if (in_use != '0) value_err("in_use after reset", int'(in_use), 0);
        if (alloc_count != '0) value_err("alloc_count after reset", int'(alloc_count), 0);
        if (dealloc_count != '0) begin
            value_err("dealloc_count after reset", int'(dealloc_count), 0);
        end
        if (err_count != '0) value_err("err_count after reset", int'(err_count), 0);
        // Init sweep writes one memory row per cycle
        wait_cnt = 1;
        while (!ready) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt > NUM_ROWS + 1) begin
            other_err($sformatf("ready rose %0d cycles after reset, later than %0d",
                                wait_cnt, NUM_ROWS + 1));
        end
    endtask

    // Take pointers until max_n or until alloc_rdy stays low for IDLE_LIMIT cycles
    task automatic take_allocs(input int max_n, output int got);
        int idle;
        got  = 0;
        idle = 0;
        while (got < max_n && idle < IDLE_LIMIT) begin
            @(negedge clk);
            alloc_req = 1'b0;
            if (alloc_rdy) begin
                check_alloc(alloc_ptr);
                alloc_req = 1'b1;
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        @(negedge clk);
        alloc_req = 1'b0;
    endtask

    // Hold the request until the deallocation queue accepts it
    task automatic free_ptr(input ptr_t p);
        @(negedge clk);
        dealloc_req = 1'b1;
        dealloc_ptr = p;
        while (!dealloc_rdy) @(negedge clk);
        @(negedge clk);
        dealloc_req      = 1'b0;
        shadow_free[p]   = 1'b1;
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    task automatic test_ascending();
        int got;
        reset_dut(0, 1'b1, 1'b1);
        take_allocs(40, got);
        if (got != 40) value_err("pointers received in ascending test", got, 40);
    endtask

    task automatic test_exhaustion();
        int got;
        reset_dut(0, 1'b1, 1'b1);
        take_allocs(POOL_SIZE + 16, got);
        if (got != POOL_SIZE) value_err("pointers received before exhaustion", got, POOL_SIZE);
        if (shadow_free != '0) other_err("some pointers were never handed out");
        if (int'(in_use) != POOL_SIZE) value_err("in_use after exhaustion", int'(in_use), POOL_SIZE);
        if (int'(alloc_count) != POOL_SIZE) begin
            value_err("alloc_count after exhaustion", int'(alloc_count), POOL_SIZE);
        end
    endtask

    task automatic test_limit();
        int got;
        reset_dut(20, 1'b1, 1'b1);
        take_allocs(POOL_SIZE, got);
        if (got != 20) value_err("pointers received with limit 20", got, 20);
        if (int'(alloc_count) != 20) value_err("alloc_count with limit 20", int'(alloc_count), 20);
    endtask

    task automatic test_free_reuse();
        int                   got;
        int                   n;
        ptr_t                 p;
        logic [POOL_SIZE-1:0] picked;
        reset_dut(0, 1'b1, 1'b1);
        take_allocs(POOL_SIZE + 16, got);
        // Park the scanner on row 0, a limit of 1 makes its row walk wrap there
        @(negedge clk);
        cur_limit = 1;
        ptr_limit = count_t'(1);
        repeat (100) @(negedge clk);
        scan_en = 1'b0;
        repeat (100) @(negedge clk);
        // Five distinct random pointers
        picked = '0;
        n      = 0;
        while (n < 5) begin
            rng_state = xorshift32(rng_state);
            p         = rng_state[7:0];
            if (!picked[p]) begin
                picked[p] = 1'b1;
                free_ptr(p);
                n++;
            end
        end
        while (int'(dealloc_count) < 5) @(negedge clk);
        if (int'(dealloc_count) != 5) begin
            value_err("dealloc_count after five frees", int'(dealloc_count), 5);
        end
        if (int'(in_use) != POOL_SIZE - 5) begin
            value_err("in_use after five frees", int'(in_use), POOL_SIZE - 5);
        end
        // Resume over the whole pool, scan restarts at row 0
        cur_limit = 0;
        ptr_limit = '0;
        scan_en   = 1'b1;
        take_allocs(5, got);
        if (got != 5) value_err("pointers reused after five frees", got, 5);
    endtask

    task automatic test_double_free();
        int   got;
        int   base_dealloc;
        int   base_err;
        ptr_t p;
        reset_dut(0, 1'b1, 1'b1);
        take_allocs(POOL_SIZE + 16, got);
        // No claims while the pointer is freed twice
        @(negedge clk);
        en           = 1'b0;
        rng_state    = xorshift32(rng_state);
        p            = rng_state[7:0];
        base_dealloc = int'(dealloc_count);
        base_err     = int'(err_count);
        free_ptr(p);
        while (int'(dealloc_count) < base_dealloc + 1) @(negedge clk);
        free_ptr(p);
        while (int'(err_count) < base_err + 1) @(negedge clk);
        repeat (50) @(negedge clk);
        if (int'(err_count) != base_err + 1) begin
            value_err("err_count after double free", int'(err_count), base_err + 1);
        end
        if (int'(dealloc_count) != base_dealloc + 1) begin
            value_err("dealloc_count after double free", int'(dealloc_count), base_dealloc + 1);
        end
        en = 1'b1;
        take_allocs(POOL_SIZE, got);
        if (got != 1) value_err("pointers received after double free", got, 1);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        srst        = 1'b1;
        en          = 1'b0;
        scan_en     = 1'b0;
        ptr_limit   = '0;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        cur_limit   = 0;
        shadow_free = '1;
        rng_state   = 32'h0a25b79c;
        value_errs  = 0;
        other_errs  = 0;

        test_ascending();
        test_exhaustion();
        test_limit();
        test_free_reuse();
        test_double_free();

        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
alloc_pkg.sv
fifo_sync.sv
bv_mem.sv
alloc_bv_core.sv
alloc_mon.sv
ptr_alloc_top.sv
tb_ptr_alloc.sv
